//--- hdl/char_pkg.sv
// layout constants assume a 640x480 mono frame buffer, one byte per 8 pixels, 10-line text rows
package char_pkg;

	// screen geometry
	localparam integer SCREEN_COLS = 80; // bytes per pixel line
	localparam integer CELL_LINES = 10; // 8 glyph lines plus blank spacing
	localparam integer ROW_PITCH = SCREEN_COLS * CELL_LINES;
	localparam integer GLYPH_LINES = 8;
	localparam integer FB_SIZE = 38400; // 80 x 480
	localparam integer ADDR_W = 16;

	// data widths
	localparam integer DATA_W = 32;
	localparam integer PC_W = 16;
	localparam integer PC_DEPTH = 10;
	localparam integer NUM_REGS = 32;
	localparam integer REG_SEL_W = 5;

	// field placement in character rows and columns
	localparam integer CYC_ROW = 0;
	localparam integer CYC_COL = 0;
	localparam integer PC_ROW0 = 1;
	localparam integer PC_COL = 0;
	localparam integer REG_ROW0 = 0;
	localparam integer REG_COL = 10;

	localparam integer CYC_DIGITS = 4;
	localparam integer PC_DIGITS = 4;
	localparam integer REG_DIGITS = 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [3:0] nibble_t;
	typedef logic [7:0] glyph_line_t; // leftmost pixel in msb

endpackage

//--- hdl/pc_history.sv
// history of distinct pc values, entry 0 newest in the low bits; repeats of the newest pc are ignored
`timescale 1ns/1ps

module pc_history (
	input  logic clock,
	input  logic arst_n,
	input  logic [char_pkg::PC_W-1:0] pc,
	input  logic pc_valid,
	output logic [char_pkg::PC_DEPTH*char_pkg::PC_W-1:0] history
);

	localparam integer W = char_pkg::PC_W;
	localparam integer D = char_pkg::PC_DEPTH;

	logic new_pc;

	assign new_pc = pc_valid && (pc != history[W-1:0]); // only a changed pc shifts

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			history <= '0;
		end else if (new_pc) begin
			history <= {history[(D-1)*W-1:0], pc}; // oldest entry drops off the top
		end
	end

endmodule

//--- hdl/field_sequencer.sv
// walks cycle, pc and register fields each frame; reg_data must be valid the cycle after reg_sel
`timescale 1ns/1ps

module field_sequencer (
	input  logic clock,
	input  logic arst_n,
	input  logic [char_pkg::PC_W-1:0] cycle_count,
	input  logic [char_pkg::PC_DEPTH*char_pkg::PC_W-1:0] history,
	input  logic [char_pkg::DATA_W-1:0] reg_data,
	input  logic busy,
	output logic [char_pkg::REG_SEL_W-1:0] reg_sel,
	output logic field_start,
	output logic [char_pkg::DATA_W-1:0] field_value,
	output logic [3:0] field_digits,
	output logic [5:0] field_row,
	output logic [6:0] field_col,
	output logic frame_done
);

	typedef enum logic [1:0] {S_LOAD, S_FETCH, S_START, S_WAIT} state_t;
	typedef enum logic [1:0] {F_CYC, F_PC, F_REG} field_t;

	state_t state;
	field_t fld;
	logic [char_pkg::REG_SEL_W-1:0] idx; // entry within the current field kind
	logic [char_pkg::DATA_W-1:0] value_q;

	assign field_start = (state == S_START) && !busy;
	assign field_value = (fld == F_REG) ? reg_data : value_q; // register value lands on start cycle

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_LOAD;
			fld <= F_CYC;
			idx <= '0;
			reg_sel <= '0;
			frame_done <= 1'b0;
			field_digits <= '0;
			field_row <= '0;
			field_col <= '0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				S_LOAD: begin
					case (fld)
						F_CYC: begin
							field_digits <= 4'(char_pkg::CYC_DIGITS);
							field_row <= 6'(char_pkg::CYC_ROW);
							field_col <= 7'(char_pkg::CYC_COL);
							state <= S_START;
						end
						F_PC: begin
							field_digits <= 4'(char_pkg::PC_DIGITS);
							field_row <= 6'(char_pkg::PC_ROW0 + int'(idx));
							field_col <= 7'(char_pkg::PC_COL);
							state <= S_START;
						end
						default: begin
							reg_sel <= idx;
							field_digits <= 4'(char_pkg::REG_DIGITS);
							field_row <= 6'(char_pkg::REG_ROW0 + int'(idx));
							field_col <= 7'(char_pkg::REG_COL);
							state <= S_FETCH; // one cycle for the register file
						end
					endcase
				end
				S_FETCH: state <= S_START;
				S_START: if (!busy) state <= S_WAIT;
				S_WAIT: begin
					if (!busy) begin // writer finished the field
						state <= S_LOAD;
						case (fld)
							F_CYC: fld <= F_PC;
							F_PC: begin
								if (idx == char_pkg::REG_SEL_W'(char_pkg::PC_DEPTH - 1)) begin
									fld <= F_REG;
									idx <= '0;
								end else begin
									idx <= idx + 1'b1;
								end
							end
							default: begin
								if (idx == char_pkg::REG_SEL_W'(char_pkg::NUM_REGS - 1)) begin
									fld <= F_CYC;
									idx <= '0;
									frame_done <= 1'b1;
								end else begin
									idx <= idx + 1'b1;
								end
							end
						endcase
					end
				end
				default: state <= S_LOAD;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == S_LOAD) begin
			if (fld == F_CYC) value_q <= char_pkg::DATA_W'(cycle_count);
			else value_q <= char_pkg::DATA_W'(history[idx*char_pkg::PC_W +: char_pkg::PC_W]);
		end
	end

endmodule

//--- hdl/glyph_rom.sv
// hex digit bitmaps only, line 0 at the top; msb is the leftmost pixel
`timescale 1ns/1ps

module glyph_rom (
	input  char_pkg::nibble_t digit,
	input  logic [2:0] line_idx,
	output char_pkg::glyph_line_t glyph_line
);

	logic [63:0] bitmap; // line 0 in the top byte

	always_comb begin
		case (digit)
			4'h0: bitmap = 64'h3C42_4242_4242_423C;
			4'h1: bitmap = 64'h1838_7818_1818_187E;
			4'h2: bitmap = 64'h3C66_660C_1830_607E;
			4'h3: bitmap = 64'h7C06_067C_0606_067C;
			4'h4: bitmap = 64'h0E16_2646_467E_0606;
			4'h5: bitmap = 64'h7E60_6078_0C06_0C78;
			4'h6: bitmap = 64'h3C40_407C_4242_423C;
			4'h7: bitmap = 64'h7E06_0606_0C18_3060;
			4'h8: bitmap = 64'h3C42_423C_4242_423C;
			4'h9: bitmap = 64'h3C46_4646_3E06_0606;
			4'hA: bitmap = 64'h3C42_4242_7E42_4242;
			4'hB: bitmap = 64'h7C42_427C_4642_467C;
			4'hC: bitmap = 64'h3E60_6060_6060_603E;
			4'hD: bitmap = 64'h7C62_6262_6262_627C;
			4'hE: bitmap = 64'h3E60_607E_6060_603E;
			default: bitmap = 64'h7E60_607E_6060_6060; // F
		endcase
		glyph_line = bitmap[(3'd7 - line_idx) * 8 +: 8];
	end

endmodule

//--- hdl/char_writer.sv
// writes one field of 1 to 8 hex digits; a new field_start is accepted only while busy is low
`timescale 1ns/1ps

module char_writer (
	input  logic clock,
	input  logic arst_n,
	input  logic field_start,
	input  logic [char_pkg::DATA_W-1:0] field_value,
	input  logic [3:0] field_digits,
	input  logic [5:0] field_row,
	input  logic [6:0] field_col,
	input  char_pkg::glyph_line_t glyph_line,
	output char_pkg::nibble_t digit,
	output logic [2:0] line_idx,
	output logic busy,
	output logic mem_we,
	output char_pkg::addr_t mem_addr,
	output char_pkg::glyph_line_t mem_data
);

	logic running_q;
	logic [2:0] line_q;
	logic [3:0] digits_left_q; // includes the digit being drawn
	logic [char_pkg::DATA_W-1:0] shift_q; // next digit in the top nibble
	char_pkg::addr_t digit_base_q, line_addr_q;

	logic active;
	logic [5:0] shift_amt;
	logic [char_pkg::DATA_W-1:0] cur_value;
	char_pkg::addr_t start_base, cur_addr;

	always_comb begin
		active = field_start | running_q;
		shift_amt = 6'((char_pkg::DATA_W / 4 - int'(field_digits)) * 4);
		// row base is computed once per field
		start_base = char_pkg::addr_t'(field_row) * char_pkg::addr_t'(char_pkg::ROW_PITCH)
			+ char_pkg::addr_t'(field_col);
		if (field_start) begin // first write comes straight from the inputs
			cur_value = field_value << shift_amt;
			line_idx = 3'd0;
			cur_addr = start_base;
		end else begin
			cur_value = shift_q;
			line_idx = line_q;
			cur_addr = line_addr_q;
		end
		digit = cur_value[char_pkg::DATA_W-1 -: 4];
	end

	assign busy = mem_we; // high until the last write has gone out

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			running_q <= 1'b0;
			line_q <= '0;
			digits_left_q <= '0;
			mem_we <= 1'b0;
		end else begin
			mem_we <= active;
			if (field_start) begin
				running_q <= 1'b1;
				line_q <= 3'd1;
				digits_left_q <= field_digits;
			end else if (running_q) begin
				line_q <= line_q + 1'b1; // wraps to 0 after line 7
				if (line_q == 3'd7) begin
					digits_left_q <= digits_left_q - 1'b1;
					if (digits_left_q == 4'd1) running_q <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (field_start) begin
			shift_q <= cur_value;
			digit_base_q <= start_base;
			line_addr_q <= start_base + char_pkg::addr_t'(char_pkg::SCREEN_COLS);
		end else if (running_q) begin
			if (line_q == 3'd7) begin // step to the next character cell
				shift_q <= shift_q << 4;
				digit_base_q <= digit_base_q + 1'b1;
				line_addr_q <= digit_base_q + 1'b1;
			end else begin
				line_addr_q <= line_addr_q + char_pkg::addr_t'(char_pkg::SCREEN_COLS);
			end
		end
		if (active) begin
			mem_addr <= cur_addr;
			mem_data <= glyph_line;
		end
	end

endmodule

//--- hdl/char_engine.sv
// hex debug screen renderer; frame buffer must accept a write every cycle, mem_addr is valid with mem_we only
`timescale 1ns/1ps

module char_engine (
	input  logic clock,
	input  logic arst_n,
	input  logic [char_pkg::DATA_W-1:0] reg_data,
	input  logic [char_pkg::PC_W-1:0] pc,
	input  logic pc_valid,
	input  logic [char_pkg::PC_W-1:0] cycle_count,
	output logic [char_pkg::REG_SEL_W-1:0] reg_sel,
	output logic mem_we,
	output char_pkg::addr_t mem_addr,
	output char_pkg::glyph_line_t mem_data,
	output logic frame_done
);

	logic [char_pkg::PC_DEPTH*char_pkg::PC_W-1:0] history;
	logic field_start, busy;
	logic [char_pkg::DATA_W-1:0] field_value;
	logic [3:0] field_digits;
	logic [5:0] field_row;
	logic [6:0] field_col;
	char_pkg::nibble_t digit;
	logic [2:0] line_idx;
	char_pkg::glyph_line_t glyph_line;

	pc_history u_history (
		.clock(clock), .arst_n(arst_n), .pc(pc), .pc_valid(pc_valid), .history(history)
	);

	field_sequencer u_seq (
		.clock(clock), .arst_n(arst_n), .cycle_count(cycle_count), .history(history),
		.reg_data(reg_data), .busy(busy), .reg_sel(reg_sel), .field_start(field_start),
		.field_value(field_value), .field_digits(field_digits), .field_row(field_row),
		.field_col(field_col), .frame_done(frame_done)
	);

	char_writer u_writer (
		.clock(clock), .arst_n(arst_n), .field_start(field_start), .field_value(field_value),
		.field_digits(field_digits), .field_row(field_row), .field_col(field_col),
		.glyph_line(glyph_line), .digit(digit), .line_idx(line_idx), .busy(busy),
		.mem_we(mem_we), .mem_addr(mem_addr), .mem_data(mem_data)
	);

	glyph_rom u_rom (
		.digit(digit), .line_idx(line_idx), .glyph_line(glyph_line)
	);

endmodule

//--- sim/char_engine_props.sv
// checks top-level port behaviour only; bound into every char_engine instance
`timescale 1ns/1ps

module char_engine_props (
	input logic clock,
	input logic arst_n,
	input logic mem_we,
	input char_pkg::addr_t mem_addr,
	input logic frame_done
);

	addr_in_range: assert property (@(posedge clock) disable iff (!arst_n)
		mem_we |-> (int'(mem_addr) < char_pkg::FB_SIZE))
		else $error("mem_addr %0d lies beyond the frame buffer", mem_addr);

	done_single: assert property (@(posedge clock) disable iff (!arst_n)
		frame_done |=> !frame_done) // one-cycle pulse
		else $error("frame_done high on two consecutive cycles");

	quiet_in_reset: assert property (@(posedge clock) !arst_n |-> !mem_we)
		else $error("mem_we high during reset");

endmodule

bind char_engine char_engine_props u_props (
	.clock(clock), .arst_n(arst_n), .mem_we(mem_we), .mem_addr(mem_addr),
	.frame_done(frame_done)
);

//--- sim/char_engine_tb.sv
// reads sim/char_engine_tests.txt relative to the run directory; stops at the first mismatch
`timescale 1ns/1ps

module char_engine_tb;

	logic clock;
	logic arst_n;
	logic [char_pkg::DATA_W-1:0] reg_data;
	logic [char_pkg::PC_W-1:0] pc;
	logic pc_valid;
	logic [char_pkg::PC_W-1:0] cycle_count;
	logic [char_pkg::REG_SEL_W-1:0] reg_sel;
	logic mem_we;
	char_pkg::addr_t mem_addr;
	char_pkg::glyph_line_t mem_data;
	logic frame_done;

	logic [31:0] tests [0:174]; // 32 regs, 14 pc values, cycle value, 128 glyph lines
	logic [7:0] fb [0:char_pkg::FB_SIZE-1];
	logic [char_pkg::PC_W-1:0] pc_expect [0:char_pkg::PC_DEPTH-1]; // entry 0 newest
	logic [char_pkg::REG_SEL_W-1:0] prev_sel, next_sel;
	integer pc_seq_len = 14;
	integer seed, cyc_slot, glyph_base, i;
	integer tick_count, cycle_limit;
	integer frames_seen, frame_writes, burst_len, sel_changes;

	char_engine UUT (
		.clock(clock), .arst_n(arst_n), .reg_data(reg_data), .pc(pc), .pc_valid(pc_valid),
		.cycle_count(cycle_count), .reg_sel(reg_sel), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_data(mem_data), .frame_done(frame_done)
	);

	function automatic integer total_writes();
		return 8 * (char_pkg::CYC_DIGITS + char_pkg::PC_DEPTH * char_pkg::PC_DIGITS
			+ char_pkg::NUM_REGS * char_pkg::REG_DIGITS);
	endfunction

	function automatic integer frame_bound();
		integer fields;
		fields = 1 + char_pkg::PC_DEPTH + char_pkg::NUM_REGS;
		return total_writes() + 4 * fields; // load, fetch, start and release per field
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("error: time %0t %s expected %h actual %h", $time, name, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "mismatch stops the run");
		end
	endtask

	task automatic check_field(input string name, input logic [31:0] value,
		input integer digits, input integer row, input integer col);
		integer d, l, addr;
		logic [3:0] nib;
		for (d = 0; d < digits; d++) begin
			nib = 4'((value >> (4 * (digits - 1 - d))) & 32'hF); // msb digit first
			for (l = 0; l < char_pkg::GLYPH_LINES; l++) begin
				addr = row * char_pkg::ROW_PITCH + l * char_pkg::SCREEN_COLS + col + d;
				check_value($sformatf("mem_data at fb[%0d] (%s digit %0d line %0d)",
					addr, name, d, l), tests[glyph_base + int'(nib) * 8 + l], {24'h0, fb[addr]});
			end
		end
	endtask

	task automatic apply_pc_sequence();
		integer n, k, gap;
		logic [char_pkg::PC_W-1:0] v;
		for (n = 0; n < pc_seq_len; n++) begin
			v = tests[char_pkg::NUM_REGS + n][char_pkg::PC_W-1:0];
			if (v != pc_expect[0]) begin // only a new value enters the history
				for (k = char_pkg::PC_DEPTH - 1; k > 0; k--) begin
					pc_expect[k] = pc_expect[k-1];
				end
				pc_expect[0] = v;
			end
			pc <= v;
			pc_valid <= 1'b1;
			@(posedge clock);
			pc_valid <= 1'b0;
			pc <= ~v; // pc moves while pc_valid is low
			gap = 1 + ($random(seed) & 3);
			repeat (gap) @(posedge clock);
		end
	endtask

	task automatic wait_frame_done();
		@(posedge clock);
		while (frame_done !== 1'b1) begin
			@(posedge clock);
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		reg_data <= tests[reg_sel]; // register file answers one cycle later
		if (mem_we) fb[mem_addr] <= mem_data;
	end

	always @(posedge clock) begin
		if (arst_n) begin
			if (mem_we) begin
				burst_len = burst_len + 1;
				frame_writes = frame_writes + 1;
			end else if (burst_len != 0) begin
				check_value("mem_we burst length mod 8", 0, burst_len % 8);
				burst_len = 0;
			end
			if (reg_sel != prev_sel) begin
				check_value("reg_sel", {27'h0, next_sel}, {27'h0, reg_sel});
				next_sel = next_sel + 1'b1;
				sel_changes = sel_changes + 1;
			end
			prev_sel = reg_sel;
			if (frame_done) begin
				check_value("mem_we writes per frame", total_writes(), frame_writes);
				// register 0 is already selected out of reset in the first frame
				check_value("reg_sel steps per frame",
					(frames_seen == 0) ? char_pkg::NUM_REGS - 1 : char_pkg::NUM_REGS, sel_changes);
				frame_writes = 0;
				sel_changes = 0;
				frames_seen = frames_seen + 1;
			end
		end
	end

	always @(posedge clock) begin
		tick_count = tick_count + 1;
		if (tick_count > cycle_limit) begin
			$display("timeout: second frame_done not seen within %0d cycles", cycle_limit);
			$display("Result: FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	initial begin
		seed = 32'h2628;
		arst_n <= 1'b0;
		reg_data <= '0;
		pc <= '0;
		pc_valid <= 1'b0;
		tick_count = 0;
		frames_seen = 0;
		frame_writes = 0;
		burst_len = 0;
		sel_changes = 0;
		prev_sel = '0;
		next_sel = 5'd1;
		cyc_slot = char_pkg::NUM_REGS + pc_seq_len;
		glyph_base = cyc_slot + 1;
		cycle_limit = 3 * frame_bound() + 16 + 5 * pc_seq_len;
		for (i = 0; i < char_pkg::PC_DEPTH; i++) begin
			pc_expect[i] = '0;
		end
		$readmemh("sim/char_engine_tests.txt", tests);
		cycle_count <= tests[cyc_slot][char_pkg::PC_W-1:0];
		if ($isunknown(tests[174])) begin
			$display("data file sim/char_engine_tests.txt is missing or too short");
			$display("Result: FAILED");
			$fatal(1, "no stimulus");
		end
		repeat (16) @(posedge clock);
		arst_n <= 1'b1;
		apply_pc_sequence(); // finishes long before the second frame
		wait_frame_done();
		wait_frame_done();
		@(negedge clock);
		check_field("cycle", {16'h0, cycle_count}, char_pkg::CYC_DIGITS,
			char_pkg::CYC_ROW, char_pkg::CYC_COL);
		for (i = 0; i < char_pkg::PC_DEPTH; i++) begin
			check_field($sformatf("pc %0d", i), {16'h0, pc_expect[i]}, char_pkg::PC_DIGITS,
				char_pkg::PC_ROW0 + i, char_pkg::PC_COL);
		end
		for (i = 0; i < char_pkg::NUM_REGS; i++) begin
			check_field($sformatf("reg %0d", i), tests[i], char_pkg::REG_DIGITS,
				char_pkg::REG_ROW0 + i, char_pkg::REG_COL);
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- sim/char_engine_tests.txt
// 32 register values, then 14 pc values with repeats, then the cycle value, all hex
// then one glyph per line for digits 0 to F, lines 0 to 7 top to bottom, msb leftmost
01234567 89ABCDEF FEDCBA98 76543210
DEADBEEF CAFEF00D 0000FFFF FFFF0000
13579BDF 2468ACE0 00000000 FFFFFFFF
A5A5A5A5 5A5A5A5A 0F1E2D3C 4B5A6978
87968BA4 C3D2E1F0 11111111 EEEEEEEE
BADC0FFE 0BADF00D 1234ABCD 9876FEDC
00000001 80000000 7FFFFFFF 55AA33CC
F00DFACE 3C3C3C3C C0FFEE11 ACE0BA5E
// pc sequence
1000 1000 1004 1008 1008 1008 100C
2000 2000 2004 3F10 3F10 ABCD 0123
// cycle value
3A7C
// glyphs 0 to F
3C 42 42 42 42 42 42 3C
18 38 78 18 18 18 18 7E
3C 66 66 0C 18 30 60 7E
7C 06 06 7C 06 06 06 7C
0E 16 26 46 46 7E 06 06
7E 60 60 78 0C 06 0C 78
3C 40 40 7C 42 42 42 3C
7E 06 06 06 0C 18 30 60
3C 42 42 3C 42 42 42 3C
3C 46 46 46 3E 06 06 06
3C 42 42 42 7E 42 42 42
7C 42 42 7C 46 42 46 7C
3E 60 60 60 60 60 60 3E
7C 62 62 62 62 62 62 7C
3E 60 60 7E 60 60 60 3E
7E 60 60 7E 60 60 60 60

//--- char_engine.f
hdl/char_pkg.sv
hdl/pc_history.sv
hdl/field_sequencer.sv
hdl/glyph_rom.sv
hdl/char_writer.sv
hdl/char_engine.sv
sim/char_engine_props.sv
sim/char_engine_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= char_engine_tb
FILELIST ?= char_engine.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
TESTS ?= sim/char_engine_tests.txt
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(TESTS)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
